// File: Makefile
VERILATOR ?= verilator
FILELIST  ?= project.f
TOP       ?= rv_core_tb
LINT_TOP  ?= rv_core
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q '>>> FAIL' $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q '>>> PASS' $(LOG); then echo "simulation did not finish"; exit 1; fi

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(LINT_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: project.f
+incdir+verilog
verilog/rv_pkg.sv
verilog/rv_fwd_if.sv
verilog/rv_regfile.sv
verilog/rv_fetch.sv
verilog/rv_decode.sv
verilog/rv_execute.sv
verilog/rv_commit.sv
verilog/rv_core.sv
sim/rv_clock_gen.sv
sim/rv_core_tb.sv

// File: sim/rv_clock_gen.sv
module rv_clock_gen (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    rst <= 1'b1;
  end

  always #50 clk = ~clk;

  // reset held for eight rising edges
  initial begin
    repeat (8) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

// File: sim/rv_core_tb.sv
`include "rv_config.svh"

module rv_core_tb import rv_pkg::*;;

  localparam int PROG_LEN = 50;
  localparam int TIMEOUT = 8 + 4 + 3 * PROG_LEN + 20;
  localparam logic [31:0] ECALL = 32'h0000_0073;

  logic                       clk;
  logic                       rst;
  logic [`XLEN-1:0]           insn_from_imem;
  logic [`XLEN-1:0]           pc_to_imem;
  logic                       halt;
  logic [`XLEN-1:0]           wb_pc;
  logic [`XLEN-1:0]           wb_insn;
  cycle_status_e              wb_status;
  logic [`REG_ADDR_WIDTH-1:0] wb_rd;
  logic [`XLEN-1:0]           wb_rd_data;
  logic                       wb_we;

  // program image and expected writeback rows
  logic [31:0] prog [PROG_LEN];
  logic [31:0] exp_pc [PROG_LEN];
  logic [31:0] exp_insn [PROG_LEN];
  logic [4:0]  exp_rd [PROG_LEN];
  logic [31:0] exp_data [PROG_LEN];
  logic        exp_we [PROG_LEN];
  logic        exp_flush [PROG_LEN];
  int          n_insn;
  int          n_rows;
  int          row;
  int          flush_left;
  int          cycles;
  logic        filled;
  logic [31:0] halt_pc;

  rv_clock_gen clock_gen_i (
    .clk (clk),
    .rst (rst)
  );

  rv_core dut_i (
    .clk                          (clk),
    .rst                          (rst),
    .insn_from_imem               (insn_from_imem),
    .pc_to_imem                   (pc_to_imem),
    .halt                         (halt),
    .trace_writeback_pc           (wb_pc),
    .trace_writeback_insn         (wb_insn),
    .trace_writeback_cycle_status (wb_status),
    .trace_writeback_rd           (wb_rd),
    .trace_writeback_rd_data      (wb_rd_data),
    .trace_writeback_we           (wb_we)
  );

  function automatic logic [31:0] encode_i(input logic [6:0] op, input logic [4:0] rd,
                                           input logic [2:0] f3, input logic [4:0] rs1,
                                           input logic [11:0] imm);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] encode_r(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] encode_b(input logic [2:0] f3, input logic [4:0] rs1,
                                           input logic [4:0] rs2, input logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] encode_j(input logic [4:0] rd, input logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
  endfunction

  // instruction that must reach writeback as the next row
  task automatic emit(input logic [31:0] insn, input logic we, input logic [4:0] rd,
                      input logic [31:0] data, input logic flush);
    prog[n_insn] = insn;
    exp_pc[n_rows] = n_insn * 4;
    exp_insn[n_rows] = insn;
    exp_rd[n_rows] = rd;
    exp_data[n_rows] = data;
    exp_we[n_rows] = we;
    exp_flush[n_rows] = flush;
    n_insn++;
    n_rows++;
  endtask

  // instruction that a taken branch must squash
  task automatic place(input logic [31:0] insn);
    prog[n_insn] = insn;
    n_insn++;
  endtask

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display(">>> FAIL");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      report_failure($sformatf("mismatch at %0t: %s is %h, expected %h",
                               $time, name, actual, expected));
    end
  endtask

  task automatic taken_pair(input logic [2:0] f3, input logic [4:0] rs1, input logic [4:0] rs2);
    emit(encode_b(f3, rs1, rs2, 13'd12), 1'b0, 5'd0, 32'h0, 1'b1);
    place(encode_i(7'b0010011, 5'd31, 3'b000, 5'd0, 12'hfff));
    place(encode_i(7'b0010011, 5'd31, 3'b000, 5'd0, 12'hfff));
  endtask

  initial begin
    insn_from_imem <= 32'h0000_0013;
    n_insn = 0;
    n_rows = 0;
    for (int k = 0; k < PROG_LEN; k++) begin
      prog[k] = ECALL;
    end
    emit({20'h80000, 5'd1, 7'b0110111}, 1'b1, 5'd1, 32'h8000_0000, 1'b0);
    emit(encode_i(7'b0010011, 5'd2, 3'b000, 5'd0, 12'hffb), 1'b1, 5'd2, 32'hffff_fffb, 1'b0);
    // x2 consumed at distances 1, 2 and 3
    emit(encode_i(7'b0010011, 5'd3, 3'b000, 5'd2, 12'd7), 1'b1, 5'd3, 32'd2, 1'b0);
    emit(encode_i(7'b0010011, 5'd4, 3'b010, 5'd2, 12'd1), 1'b1, 5'd4, 32'd1, 1'b0);
    emit(encode_i(7'b0010011, 5'd5, 3'b011, 5'd2, 12'd1), 1'b1, 5'd5, 32'd0, 1'b0);
    emit(encode_i(7'b0010011, 5'd6, 3'b100, 5'd3, 12'h0f0), 1'b1, 5'd6, 32'h0000_00f2, 1'b0);
    emit(encode_i(7'b0010011, 5'd7, 3'b110, 5'd6, 12'hf00), 1'b1, 5'd7, 32'hffff_fff2, 1'b0);
    emit(encode_i(7'b0010011, 5'd8, 3'b111, 5'd7, 12'h0ff), 1'b1, 5'd8, 32'h0000_00f2, 1'b0);
    emit(encode_i(7'b0010011, 5'd9, 3'b001, 5'd3, 12'h004), 1'b1, 5'd9, 32'h0000_0020, 1'b0);
    emit(encode_i(7'b0010011, 5'd10, 3'b101, 5'd1, 12'h004), 1'b1, 5'd10, 32'h0800_0000, 1'b0);
    emit(encode_i(7'b0010011, 5'd11, 3'b101, 5'd1, 12'h404), 1'b1, 5'd11, 32'hf800_0000, 1'b0);
    emit(encode_r(7'h00, 5'd3, 5'd2, 3'b000, 5'd12), 1'b1, 5'd12, 32'hffff_fffd, 1'b0);
    emit(encode_r(7'h20, 5'd2, 5'd3, 3'b000, 5'd13), 1'b1, 5'd13, 32'd7, 1'b0);
    emit(encode_r(7'h00, 5'd3, 5'd9, 3'b001, 5'd14), 1'b1, 5'd14, 32'h0000_0080, 1'b0);
    emit(encode_r(7'h00, 5'd3, 5'd2, 3'b010, 5'd15), 1'b1, 5'd15, 32'd1, 1'b0);
    emit(encode_r(7'h00, 5'd3, 5'd2, 3'b011, 5'd16), 1'b1, 5'd16, 32'd0, 1'b0);
    emit(encode_r(7'h00, 5'd8, 5'd6, 3'b100, 5'd17), 1'b1, 5'd17, 32'd0, 1'b0);
    emit(encode_r(7'h00, 5'd3, 5'd1, 3'b101, 5'd18), 1'b1, 5'd18, 32'h2000_0000, 1'b0);
    emit(encode_r(7'h20, 5'd3, 5'd2, 3'b101, 5'd19), 1'b1, 5'd19, 32'hffff_fffe, 1'b0);
    emit(encode_r(7'h00, 5'd14, 5'd9, 3'b110, 5'd20), 1'b1, 5'd20, 32'h0000_00a0, 1'b0);
    emit(encode_r(7'h00, 5'd12, 5'd7, 3'b111, 5'd21), 1'b1, 5'd21, 32'hffff_fff0, 1'b0);
    // x0 written, then read right behind it
    emit(encode_i(7'b0010011, 5'd0, 3'b000, 5'd0, 12'd123), 1'b1, 5'd0, 32'd123, 1'b0);
    emit(encode_r(7'h00, 5'd0, 5'd0, 3'b000, 5'd22), 1'b1, 5'd22, 32'd0, 1'b0);
    emit(encode_r(7'h00, 5'd3, 5'd0, 3'b000, 5'd23), 1'b1, 5'd23, 32'd2, 1'b0);
    taken_pair(3'b000, 5'd3, 5'd3);
    emit(encode_b(3'b000, 5'd3, 5'd2, 13'd8), 1'b0, 5'd0, 32'h0, 1'b0);
    taken_pair(3'b001, 5'd2, 5'd3);
    taken_pair(3'b100, 5'd2, 5'd3);
    taken_pair(3'b101, 5'd3, 5'd2);
    taken_pair(3'b110, 5'd3, 5'd2);
    taken_pair(3'b111, 5'd2, 5'd3);
    emit(encode_b(3'b100, 5'd3, 5'd2, 13'd8), 1'b0, 5'd0, 32'h0, 1'b0);
    emit(encode_b(3'b111, 5'd3, 5'd2, 13'd8), 1'b0, 5'd0, 32'h0, 1'b0);
    // link is pc + 4 of the jal at 180
    emit(encode_j(5'd25, 21'd12), 1'b1, 5'd25, 32'h0000_00b8, 1'b1);
    place(encode_i(7'b0010011, 5'd31, 3'b000, 5'd0, 12'hfff));
    place(encode_i(7'b0010011, 5'd31, 3'b000, 5'd0, 12'hfff));
    emit(encode_i(7'b0010011, 5'd26, 3'b000, 5'd25, 12'd1), 1'b1, 5'd26, 32'h0000_00b9, 1'b0);
    halt_pc = n_insn * 4;
    place(ECALL);
  end

  // one-cycle synchronous instruction ROM
  always @(posedge clk) begin
    if ((pc_to_imem >> 2) < PROG_LEN) begin
      insn_from_imem <= prog[pc_to_imem >> 2];
    end else begin
      insn_from_imem <= ECALL;
    end
  end

  initial begin
    cycles = 0;
    row = 0;
    flush_left = 0;
    filled = 1'b0;
  end

  always @(posedge clk) begin
    if (cycles >= TIMEOUT) begin
      report_failure($sformatf("timeout: no halt after %0d cycles", cycles));
    end
    cycles++;
  end

  // outputs are sampled on the falling edge
  always @(negedge clk) begin
    case (wb_status)
      CYCLE_RESET: begin
        if (filled) begin
          report_failure("reset status seen in writeback after instructions retired");
        end
        check_value("trace_writeback_we", wb_we, 1'b0);
        check_value("halt", halt, 1'b0);
      end
      CYCLE_TAKEN_BRANCH: begin
        if (flush_left == 0) begin
          report_failure("flush bubble in writeback without a taken branch before it");
        end
        check_value("trace_writeback_we", wb_we, 1'b0);
        check_value("halt", halt, 1'b0);
        flush_left--;
      end
      CYCLE_NO_STALL: begin
        filled = 1'b1;
        if (flush_left != 0) begin
          report_failure("instruction in writeback where a flush bubble was expected");
        end
        if (halt) begin
          check_value("trace_writeback_pc", wb_pc, halt_pc);
          check_value("trace_writeback_insn", wb_insn, ECALL);
          if (row == n_rows) begin
            $display(">>> PASS");
            $finish;
          end else begin
            report_failure($sformatf("halt raised after %0d of %0d expected rows",
                                     row, n_rows));
          end
        end else begin
          if (row >= n_rows) begin
            report_failure("more instructions retired than the program expects");
          end
          check_value("trace_writeback_pc", wb_pc, exp_pc[row]);
          check_value("trace_writeback_insn", wb_insn, exp_insn[row]);
          check_value("trace_writeback_we", wb_we, exp_we[row]);
          // rd and data only mean something for a write
          if (exp_we[row]) begin
            check_value("trace_writeback_rd", wb_rd, exp_rd[row]);
            check_value("trace_writeback_rd_data", wb_rd_data, exp_data[row]);
          end
          if (exp_flush[row]) begin
            flush_left = 2;
          end
          row++;
        end
      end
      default: begin
        report_failure("writeback status is invalid or unknown");
      end
    endcase
  end

endmodule

// File: verilog/rv_commit.sv
`include "rv_config.svh"

module rv_commit import rv_pkg::*; (
  input  logic                       clk,
  input  logic                       rst,
  rv_fwd_if.commit_mp                fwd,
  output logic                       halt,
  output logic [`XLEN-1:0]           trace_writeback_pc,
  output logic [`XLEN-1:0]           trace_writeback_insn,
  output cycle_status_e              trace_writeback_cycle_status,
  output logic [`REG_ADDR_WIDTH-1:0] trace_writeback_rd,
  output logic [`XLEN-1:0]           trace_writeback_rd_data,
  output logic                       trace_writeback_we
);

  always_ff @(posedge clk) begin
    if (rst) begin
      fwd.wb_stage <= '0;
      fwd.wb_stage.status <= CYCLE_RESET;
    end else begin
      fwd.wb_stage <= fwd.mem_stage;
    end
  end

  // level, held while the ECALL sits here
  assign halt = fwd.wb_stage.halt;

  assign trace_writeback_pc           = fwd.wb_stage.pc;
  assign trace_writeback_insn         = fwd.wb_stage.insn;
  assign trace_writeback_cycle_status = fwd.wb_stage.status;
  assign trace_writeback_rd           = fwd.wb_stage.rd;
  assign trace_writeback_rd_data      = fwd.wb_stage.rd_data;
  assign trace_writeback_we           = fwd.wb_stage.we;

  // every stage must tag its bubbles
  assert property (@(posedge clk) disable iff (rst)
    fwd.wb_stage.status != CYCLE_INVALID);

endmodule

// File: verilog/rv_config.svh
`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

// register and pc width
`define XLEN 32
`define NUM_REGS 32
`define REG_ADDR_WIDTH 5

// first fetch address after reset
`define RESET_PC 32'h0000_0000

`endif

// File: verilog/rv_core.sv
`include "rv_config.svh"

module rv_core import rv_pkg::*; (
  input  logic                       clk,
  input  logic                       rst,
  input  logic [`XLEN-1:0]           insn_from_imem,
  output logic [`XLEN-1:0]           pc_to_imem,
  output logic                       halt,
  output logic [`XLEN-1:0]           trace_writeback_pc,
  output logic [`XLEN-1:0]           trace_writeback_insn,
  output cycle_status_e              trace_writeback_cycle_status,
  output logic [`REG_ADDR_WIDTH-1:0] trace_writeback_rd,
  output logic [`XLEN-1:0]           trace_writeback_rd_data,
  output logic                       trace_writeback_we
);

  decode_stage_t    decode_stage;
  execute_stage_t   execute_stage;
  logic             branch_taken;
  logic [`XLEN-1:0] branch_target;

  rv_fwd_if fwd_if ();

  rv_fetch fetch_i (
    .clk            (clk),
    .rst            (rst),
    .insn_from_imem (insn_from_imem),
    .branch_taken   (branch_taken),
    .branch_target  (branch_target),
    .pc_to_imem     (pc_to_imem),
    .decode_stage   (decode_stage)
  );

  rv_decode decode_i (
    .clk           (clk),
    .rst           (rst),
    .decode_stage  (decode_stage),
    .branch_taken  (branch_taken),
    .fwd           (fwd_if.bypass_mp),
    .execute_stage (execute_stage)
  );

  rv_execute execute_i (
    .clk           (clk),
    .rst           (rst),
    .execute_stage (execute_stage),
    .fwd           (fwd_if.execute_mp),
    .branch_taken  (branch_taken),
    .branch_target (branch_target)
  );

  rv_commit commit_i (
    .clk                          (clk),
    .rst                          (rst),
    .fwd                          (fwd_if.commit_mp),
    .halt                         (halt),
    .trace_writeback_pc           (trace_writeback_pc),
    .trace_writeback_insn         (trace_writeback_insn),
    .trace_writeback_cycle_status (trace_writeback_cycle_status),
    .trace_writeback_rd           (trace_writeback_rd),
    .trace_writeback_rd_data      (trace_writeback_rd_data),
    .trace_writeback_we           (trace_writeback_we)
  );

endmodule

// File: verilog/rv_decode.sv
`include "rv_config.svh"

module rv_decode import rv_pkg::*; (
  input  logic           clk,
  input  logic           rst,
  input  decode_stage_t  decode_stage,
  input  logic           branch_taken,
  rv_fwd_if.bypass_mp    fwd,
  output execute_stage_t execute_stage
);

  rv_insn_u         insn;
  logic [`XLEN-1:0] rs1_data;
  logic [`XLEN-1:0] rs2_data;
  logic [`XLEN-1:0] imm_i;
  logic [`XLEN-1:0] imm_b;
  logic [`XLEN-1:0] imm_j;
  logic             wx_rs1_valid;
  logic             wx_rs2_valid;

  assign insn = decode_stage.insn;

  rv_regfile regfile_i (
    .clk      (clk),
    .rst      (rst),
    .rs1      (insn.r.rs1),
    .rs2      (insn.r.rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .fwd      (fwd)
  );

  assign imm_i = {{(`XLEN-12){insn.i.imm_hi[11]}}, insn.i.imm_hi};

  // B and J immediates are scattered over the R-type fields
  assign imm_b = {{(`XLEN-13){insn.r.funct7[6]}}, insn.r.funct7[6], insn.r.rd[0],
                  insn.r.funct7[5:0], insn.r.rd[4:1], 1'b0};
  assign imm_j = {{(`XLEN-21){insn.r.funct7[6]}}, insn.r.funct7[6], insn.r.rs1,
                  insn.r.funct3, insn.r.rs2[0], insn.r.funct7[5:0], insn.r.rs2[4:1], 1'b0};

  // producer two ahead sits in memory now, in writeback next cycle
  assign wx_rs1_valid = fwd.mem_stage.we && fwd.mem_stage.rd == insn.r.rs1 && insn.r.rs1 != '0;
  assign wx_rs2_valid = fwd.mem_stage.we && fwd.mem_stage.rd == insn.r.rs2 && insn.r.rs2 != '0;

  always_ff @(posedge clk) begin
    if (rst || branch_taken) begin
      execute_stage <= '0;
      execute_stage.status <= rst ? CYCLE_RESET : CYCLE_TAKEN_BRANCH;
    end else begin
      execute_stage <= '{
        pc:           decode_stage.pc,
        insn:         insn,
        status:       decode_stage.status,
        rs1_data:     rs1_data,
        rs2_data:     rs2_data,
        imm_i:        imm_i,
        imm_b:        imm_b,
        imm_j:        imm_j,
        wx_rs1_valid: wx_rs1_valid,
        wx_rs1_data:  fwd.mem_stage.rd_data,
        wx_rs2_valid: wx_rs2_valid,
        wx_rs2_data:  fwd.mem_stage.rd_data
      };
    end
  end

endmodule

// File: verilog/rv_execute.sv
`include "rv_config.svh"

module rv_execute import rv_pkg::*; (
  input  logic             clk,
  input  logic             rst,
  input  execute_stage_t   execute_stage,
  rv_fwd_if.execute_mp     fwd,
  output logic             branch_taken,
  output logic [`XLEN-1:0] branch_target
);

  rv_insn_u         insn;
  logic [`XLEN-1:0] op_a;
  logic [`XLEN-1:0] op_b;
  logic [`XLEN-1:0] result;
  logic             rd_we;
  logic             is_halt;
  logic             illegal;
  logic             alt;

  assign insn = execute_stage.insn;

  // MX first, then the value captured for WX, then the register file
  function automatic logic [`XLEN-1:0] resolve(
    input logic [`REG_ADDR_WIDTH-1:0] addr,
    input logic [`XLEN-1:0]           rf_data,
    input logic                       wx_valid,
    input logic [`XLEN-1:0]           wx_data,
    input commit_stage_t              mem
  );
    if (mem.we && mem.rd == addr && addr != '0) begin
      return mem.rd_data;
    end else if (wx_valid) begin
      return wx_data;
    end else begin
      return rf_data;
    end
  endfunction

  // shared by OP and OP_IMM, alt selects SUB or SRA
  function automatic logic [`XLEN-1:0] alu(
    input logic [2:0]       funct3,
    input logic             alt_op,
    input logic [`XLEN-1:0] a,
    input logic [`XLEN-1:0] b
  );
    case (funct3)
      3'b000: return alt_op ? a - b : a + b;
      3'b001: return a << b[4:0];
      3'b010: return {{(`XLEN-1){1'b0}}, $signed(a) < $signed(b)};
      3'b011: return {{(`XLEN-1){1'b0}}, a < b};
      3'b100: return a ^ b;
      3'b101: return alt_op ? `XLEN'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'b110: return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic branch_cond(
    input logic [2:0]       funct3,
    input logic [`XLEN-1:0] a,
    input logic [`XLEN-1:0] b
  );
    case (funct3)
      3'b000: return a == b;
      3'b001: return a != b;
      3'b100: return $signed(a) < $signed(b);
      3'b101: return $signed(a) >= $signed(b);
      3'b110: return a < b;
      3'b111: return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  always_comb begin
    op_a = resolve(insn.r.rs1, execute_stage.rs1_data, execute_stage.wx_rs1_valid,
                   execute_stage.wx_rs1_data, fwd.mem_stage);
    op_b = resolve(insn.r.rs2, execute_stage.rs2_data, execute_stage.wx_rs2_valid,
                   execute_stage.wx_rs2_data, fwd.mem_stage);
    result = '0;
    rd_we = 1'b0;
    is_halt = 1'b0;
    illegal = 1'b0;
    alt = 1'b0;
    branch_taken = 1'b0;
    branch_target = execute_stage.pc + execute_stage.imm_b;
    case (insn.r.opcode)
      OPC_LUI: begin
        result = {execute_stage.insn[31:12], 12'b0};
        rd_we = 1'b1;
      end
      OPC_OP_IMM: begin
        // funct7 only matters for the shifts
        alt = insn.r.funct3 == 3'b101 && insn.r.funct7 == 7'b0100000;
        illegal = (insn.r.funct3 == 3'b001 && insn.r.funct7 != '0) ||
                  (insn.r.funct3 == 3'b101 && insn.r.funct7 != '0 && !alt);
        result = alu(insn.r.funct3, alt, op_a, execute_stage.imm_i);
        rd_we = !illegal;
      end
      OPC_OP: begin
        alt = insn.r.funct7 == 7'b0100000;
        illegal = !(insn.r.funct7 == '0 ||
                    (alt && (insn.r.funct3 == 3'b000 || insn.r.funct3 == 3'b101)));
        result = alu(insn.r.funct3, alt, op_a, op_b);
        rd_we = !illegal;
      end
      OPC_BRANCH: begin
        illegal = insn.r.funct3 == 3'b010 || insn.r.funct3 == 3'b011;
        branch_taken = branch_cond(insn.r.funct3, op_a, op_b);
      end
      OPC_JAL: begin
        result = execute_stage.pc + `XLEN'd4;
        rd_we = 1'b1;
        branch_taken = 1'b1;
        branch_target = execute_stage.pc + execute_stage.imm_j;
      end
      OPC_SYSTEM: begin
        // only the all-zero ECALL
        is_halt = execute_stage.insn[31:7] == '0;
        illegal = !is_halt;
      end
      default: begin
        illegal = 1'b1;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      fwd.mem_stage <= '0;
      fwd.mem_stage.status <= CYCLE_RESET;
    end else begin
      fwd.mem_stage <= '{
        pc:      execute_stage.pc,
        insn:    insn,
        status:  execute_stage.status,
        rd:      insn.r.rd,
        rd_data: result,
        we:      rd_we,
        halt:    is_halt
      };
    end
  end

  assert property (@(posedge clk) disable iff (rst)
    execute_stage.status == CYCLE_NO_STALL |-> !illegal);

endmodule

// File: verilog/rv_fetch.sv
`include "rv_config.svh"

module rv_fetch import rv_pkg::*; (
  input  logic             clk,
  input  logic             rst,
  input  logic [`XLEN-1:0] insn_from_imem,
  input  logic             branch_taken,
  input  logic [`XLEN-1:0] branch_target,
  output logic [`XLEN-1:0] pc_to_imem,
  output decode_stage_t    decode_stage
);

  // address whose word is on insn_from_imem this cycle
  logic [`XLEN-1:0] fetch_pc;

  always_comb begin
    if (rst) begin
      pc_to_imem = `RESET_PC;
    end else if (branch_taken) begin
      pc_to_imem = branch_target;
    end else begin
      pc_to_imem = fetch_pc + `XLEN'd4;
    end
  end

  always_ff @(posedge clk) begin
    fetch_pc <= pc_to_imem;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      decode_stage <= '{pc: '0, insn: '0, status: CYCLE_RESET};
    end else if (branch_taken) begin
      // younger instruction is squashed
      decode_stage <= '{pc: '0, insn: '0, status: CYCLE_TAKEN_BRANCH};
    end else begin
      decode_stage <= '{pc: fetch_pc, insn: insn_from_imem, status: CYCLE_NO_STALL};
    end
  end

  // branch targets come from execute
  assert property (@(posedge clk) pc_to_imem[1:0] == 2'b00);

endmodule

// File: verilog/rv_fwd_if.sv
interface rv_fwd_if import rv_pkg::*; ();

  // result leaving execute
  commit_stage_t mem_stage;
  // result in writeback, also the register write port
  commit_stage_t wb_stage;

  modport execute_mp (output mem_stage, input wb_stage);

  modport commit_mp (input mem_stage, output wb_stage);

  modport bypass_mp (input mem_stage, input wb_stage);

endinterface

// File: verilog/rv_pkg.sv
`include "rv_config.svh"

package rv_pkg;

  // major opcodes of the supported subset
  typedef enum logic [6:0] {
    OPC_LUI    = 7'b0110111,
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011,
    OPC_BRANCH = 7'b1100011,
    OPC_JAL    = 7'b1101111,
    OPC_SYSTEM = 7'b1110011
  } opcode_e;

  // what occupies writeback in a given cycle
  typedef enum logic [2:0] {
    CYCLE_INVALID      = 3'd0,
    CYCLE_RESET        = 3'd1,
    CYCLE_NO_STALL     = 3'd2,
    CYCLE_TAKEN_BRANCH = 3'd4
  } cycle_status_e;

  typedef struct packed {
    logic [6:0]                 funct7;
    logic [`REG_ADDR_WIDTH-1:0] rs2;
    logic [`REG_ADDR_WIDTH-1:0] rs1;
    logic [2:0]                 funct3;
    logic [`REG_ADDR_WIDTH-1:0] rd;
    opcode_e                    opcode;
  } rv_r_view_t;

  typedef struct packed {
    logic [11:0]                imm_hi;
    logic [`REG_ADDR_WIDTH-1:0] rs1;
    logic [2:0]                 funct3;
    logic [`REG_ADDR_WIDTH-1:0] rd;
    opcode_e                    opcode;
  } rv_i_view_t;

  // one instruction word, seen as R-type or as I-type
  typedef union packed {
    rv_r_view_t r;
    rv_i_view_t i;
  } rv_insn_u;

  typedef struct packed {
    logic [`XLEN-1:0] pc;
    rv_insn_u         insn;
    cycle_status_e    status;
  } decode_stage_t;

  typedef struct packed {
    logic [`XLEN-1:0] pc;
    rv_insn_u         insn;
    cycle_status_e    status;
    logic [`XLEN-1:0] rs1_data;
    logic [`XLEN-1:0] rs2_data;
    logic [`XLEN-1:0] imm_i;
    logic [`XLEN-1:0] imm_b;
    logic [`XLEN-1:0] imm_j;
    logic             wx_rs1_valid;
    logic [`XLEN-1:0] wx_rs1_data;
    logic             wx_rs2_valid;
    logic [`XLEN-1:0] wx_rs2_data;
  } execute_stage_t;

  // memory and writeback stages carry the same fields
  typedef struct packed {
    logic [`XLEN-1:0]           pc;
    rv_insn_u                   insn;
    cycle_status_e              status;
    logic [`REG_ADDR_WIDTH-1:0] rd;
    logic [`XLEN-1:0]           rd_data;
    logic                       we;
    logic                       halt;
  } commit_stage_t;

endpackage

// File: verilog/rv_regfile.sv
`include "rv_config.svh"

module rv_regfile (
  input  logic                       clk,
  input  logic                       rst,
  input  logic [`REG_ADDR_WIDTH-1:0] rs1,
  input  logic [`REG_ADDR_WIDTH-1:0] rs2,
  output logic [`XLEN-1:0]           rs1_data,
  output logic [`XLEN-1:0]           rs2_data,
  rv_fwd_if.bypass_mp                fwd
);

  logic [`XLEN-1:0] regs [`NUM_REGS];

  // x0 reads zero, a same-cycle write is passed straight through
  function automatic logic [`XLEN-1:0] read_port(input logic [`REG_ADDR_WIDTH-1:0] addr);
    if (addr == '0) begin
      return '0;
    end else if (fwd.wb_stage.we && fwd.wb_stage.rd == addr) begin
      return fwd.wb_stage.rd_data;
    end else begin
      return regs[addr];
    end
  endfunction

  always_ff @(posedge clk) begin
    if (fwd.wb_stage.we && fwd.wb_stage.rd != '0) begin
      regs[fwd.wb_stage.rd] <= fwd.wb_stage.rd_data;
    end
  end

  always_comb begin
    rs1_data = read_port(rs1);
    rs2_data = read_port(rs2);
  end

  // destination comes all the way from decode
  assert property (@(posedge clk) disable iff (rst)
    fwd.wb_stage.we |-> !$isunknown(fwd.wb_stage.rd));

endmodule
